/* test/eeprom_cases.txt */
# op (w write, r read, b write with a second strobe while busy), addr, data,
# nack select (0 none 1 ctrl-w 2 addr 3 data 4 ctrl-r), expected nack, expected rd_data
w 000 a5 0 0 00
r 000 00 0 0 a5
w 3c7 5a 0 0 00
r 3c7 00 0 0 5a
w 712 11 0 0 00
w 212 22 0 0 00
r 712 00 0 0 11
r 212 00 0 0 22
w 212 99 2 1 00
r 212 00 0 0 22
r 000 00 4 1 22
w 454 77 0 0 00
b 455 c3 0 0 00
r 455 00 0 0 c3
r 454 00 0 0 77

/* verilog.f */
+incdir+src
src/eeprom_cmd_pkg.sv
src/eeprom_bus_pkg.sv
src/eeprom_req_stage.sv
src/eeprom_frame_seq.sv
src/eeprom_bit_engine.sv
src/eeprom_ctrl.sv
test/eeprom_model.sv
test/tb_eeprom_ctrl.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_eeprom_ctrl
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_eeprom_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eeprom_defs.svh"

module tb_eeprom_ctrl;

    localparam int MAX_CASES = 32;
    localparam int N_RAND    = 6;
    localparam int OP_R      = "r";
    localparam int OP_B      = "b";
    localparam int OP_W      = "w";

    logic                     CLK;
    logic                     RESET;
    logic                     wr;
    logic                     rd;
    logic                     busy;
    logic                     ack;
    logic                     nack;
    logic                     scl;
    logic                     sda_oe;
    logic                     model_pull;
    logic [2:0]               nack_sel;
    eeprom_cmd_pkg::ee_addr_t addr;
    eeprom_cmd_pkg::ee_byte_t wr_data;
    eeprom_cmd_pkg::ee_byte_t rd_data;
    logic [7:0]               ctrl_wr_seen;
    logic [7:0]               ctrl_rd_seen;
    int                       proto_errs;
    wire                      sda_line;

    int          c_op [MAX_CASES];
    int          c_addr [MAX_CASES];
    int          c_data [MAX_CASES];
    int          c_nsel [MAX_CASES];
    int          c_nack [MAX_CASES];
    int          c_rd [MAX_CASES];
    logic [7:0]  shadow [0:`EE_MEM_BYTES-1];
    int          n_cases = 0;
    int          cycles = 0;
    int          cycle_limit = 1000000;
    int          ack_cnt = 0;
    int          fails = 0;
    int          tests = 0;
    int          bad_tests = 0;
    logic [31:0] lcg_state;

    assign sda_line = !(sda_oe || model_pull);  // pull-up

    eeprom_ctrl u_eeprom_ctrl (.CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr),
        .wr_data(wr_data), .sda_in(sda_line), .busy(busy), .ack(ack), .nack(nack),
        .rd_data(rd_data), .scl(scl), .sda_oe(sda_oe));

    eeprom_model u_model (.scl(scl), .sda(sda_line), .nack_sel(nack_sel),
        .pull(model_pull), .err_cnt(proto_errs), .ctrl_wr_seen(ctrl_wr_seen),
        .ctrl_rd_seen(ctrl_rd_seen));

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (ack)
            ack_cnt <= ack_cnt + 1;
        if (cycles > cycle_limit)
        begin
            $display("timeout: no ack after %0d clock cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            fails++;
        end
    endtask

    task automatic load_cases();
        string line;
        int    fd;
        int    op;
        int    a;
        int    d;
        int    ns;
        int    en;
        int    er;
        fd = $fopen("test/eeprom_cases.txt", "r");
        if (fd == 0)
        begin
            $display("error: cannot open test/eeprom_cases.txt");
            fails++;
        end
        else
        begin
            while (!$feof(fd) && n_cases < MAX_CASES)
            begin
                void'($fgets(line, fd));
                if (line.len() > 2 && line[0] != "#" &&
                    $sscanf(line, "%c %h %h %d %d %h", op, a, d, ns, en, er) == 6)
                begin
                    c_op[n_cases]   = op;
                    c_addr[n_cases] = a;
                    c_data[n_cases] = d;
                    c_nsel[n_cases] = ns;
                    c_nack[n_cases] = en;
                    c_rd[n_cases]   = er;
                    n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_op(input int op, input int a, input int d, input int ns,
                          input int en, input int er);
        int    fails0;
        int    acks0;
        logic  is_rd;
        string name;
        fails0   = fails;
        acks0    = ack_cnt;
        is_rd    = (op == OP_R);
        name     = is_rd ? "read" : ((op == OP_B) ? "write+busy" : "write");
        nack_sel = 3'(ns);
        @(negedge CLK);
        wr      = !is_rd;
        rd      = is_rd;
        addr    = 11'(a);
        wr_data = 8'(d);
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        if (op == OP_B)
        begin
            check(32'(busy), 1, "busy at second strobe");
            wr      = 1'b1;  // must be dropped
            addr    = 11'(a ^ 1);
            wr_data = 8'(~d);
            @(negedge CLK);
            wr = 1'b0;
        end
        while (!ack)
            @(negedge CLK);
        check(32'(busy), 0, "busy with ack");
        check(32'(nack), en, "nack");
        if (is_rd)
            check(32'(rd_data), er, "rd_data");
        check(32'(ctrl_wr_seen), 32'({`EE_DEV_CODE, 3'(a >> 8), 1'b0}), "control byte, write");
        if (is_rd)
            check(32'(ctrl_rd_seen), 32'({`EE_DEV_CODE, 3'(a >> 8), 1'b1}), "control byte, read");
        @(negedge CLK);
        check(32'(busy), 0, "busy after ack");
        check(32'(scl), 1, "scl idle");
        check(32'(sda_oe), 0, "sda_oe idle");
        check(ack_cnt - acks0, 1, "ack count");
        if (!is_rd && en == 0)
            shadow[a] = 8'(d);
        tests++;
        if (fails != fails0)
            bad_tests++;
        $display("test %0d: %s addr %h data %h: %s", tests, name, 11'(a), 8'(d),
                 (fails == fails0) ? "ok" : "mismatch");
    endtask

    initial
    begin
        int a;
        int d;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wr_data   = '0;
        nack_sel  = 3'd0;
        RESET     = 1'b1;
        lcg_state = 32'h1666;
        for (int i = 0; i < `EE_MEM_BYTES; i++)
            shadow[i] = 8'(i) ^ {3'(i >> 8), 3'(i >> 8), 2'(i >> 9)};
        load_cases();
        // a read frame is 78 scl half periods plus a few clocks per symbol
        cycle_limit = (n_cases + 2 * N_RAND) * (100 * `EE_SCL_HALF + 40) + 100;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        check(32'(scl), 1, "scl after reset");
        check(32'(sda_oe), 0, "sda_oe after reset");
        check(32'(busy), 0, "busy after reset");
        check(32'(ack), 0, "ack after reset");
        check(32'(nack), 0, "nack after reset");
        check(32'(rd_data), 0, "rd_data after reset");
        for (int i = 0; i < n_cases; i++)
            run_op(c_op[i], c_addr[i], c_data[i], c_nsel[i], c_nack[i], c_rd[i]);
        for (int i = 0; i < N_RAND; i++)
        begin
            a = int'(lcg_next() >> 16) & 32'h7ff;
            d = int'(lcg_next() >> 24);
            run_op(OP_W, a, d, 0, 0, 0);
            run_op(OP_R, a, 0, 0, 0, int'(shadow[a]));
        end
        check(proto_errs, 0, "bus protocol errors");
        $display("%0d tests, %0d passed, %0d failed, %0d check failures",
                 tests, tests - bad_tests, bad_tests, fails);
        if (fails == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/eeprom_model.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eeprom_defs.svh"

module eeprom_model
(
    input  wire        scl,
    input  wire        sda,
    input  logic [2:0] nack_sel,  // 0 none, 1 ctrl wr, 2 addr, 3 data, 4 ctrl rd
    output logic       pull,
    output int         err_cnt,
    output logic [7:0] ctrl_wr_seen,
    output logic [7:0] ctrl_rd_seen
);

    logic [7:0]  mem [0:`EE_MEM_BYTES-1];
    logic        pull_r = 1'b0;
    int          errs = 0;
    logic [7:0]  cw_seen = 8'h00;
    logic [7:0]  cr_seen = 8'h00;
    logic        prev_scl = 1'b1;
    logic        prev_sda = 1'b1;
    logic        active = 1'b0;
    logic        slave_tx = 1'b0;
    logic        go_tx = 1'b0;
    logic        rd_mode = 1'b0;
    logic        ok;
    logic [2:0]  blk = 3'd0;
    logic [7:0]  sh = 8'h00;
    logic [7:0]  tx_byte = 8'h00;
    logic [10:0] ptr = 11'd0;
    int          bitn = 0;
    int          byte_idx = 0;

    assign pull         = pull_r;
    assign err_cnt      = errs;
    assign ctrl_wr_seen = cw_seen;
    assign ctrl_rd_seen = cr_seen;

    initial
    begin
        for (int i = 0; i < `EE_MEM_BYTES; i++)
            mem[i] = 8'(i) ^ {3'(i >> 8), 3'(i >> 8), 2'(i >> 9)};  // whole address in the fill
    end

    // decides the ack for a byte written by the master
    task automatic take_byte(input logic [7:0] b, output logic acked);
        acked = 1'b0;
        if (byte_idx == 0 && b[7:4] == `EE_DEV_CODE)
        begin
            rd_mode = b[0];
            if (!b[0])
            begin
                cw_seen = b;
                blk     = b[3:1];
                acked   = (nack_sel != 3'd1);
            end
            else
            begin
                cr_seen    = b;
                ptr[10:8]  = b[3:1];
                acked      = (nack_sel != 3'd4);
                go_tx      = acked;
            end
        end
        else if (!rd_mode && byte_idx == 1)
        begin
            ptr   = {blk, b};
            acked = (nack_sel != 3'd2);
        end
        else if (!rd_mode && byte_idx == 2)
        begin
            acked = (nack_sel != 3'd3);
            if (acked)
                mem[ptr] = b;
        end
    endtask

    always @(scl or sda)
    begin
        if (scl !== prev_scl)
        begin
            if (scl === 1'b1 && active)
            begin
                if (bitn < 8 && !slave_tx)
                    sh = {sh[6:0], sda};
                bitn = bitn + 1;
            end
            else if (scl === 1'b0 && active)
            begin
                if (bitn == 8)
                begin
                    take_byte(sh, ok);
                    pull_r = !slave_tx && ok;  // master owns the slot after a read byte
                end
                else if (bitn == 9)
                begin
                    bitn     = 0;
                    byte_idx = byte_idx + 1;
                    slave_tx = go_tx;
                    go_tx    = 1'b0;
                    tx_byte  = mem[ptr];
                    pull_r   = slave_tx && !tx_byte[7];
                end
                else if (slave_tx)
                    pull_r = !tx_byte[3'(7 - bitn)];
            end
        end
        else if (sda !== prev_sda && scl === 1'b1)
        begin
            if (active && bitn >= 2)
                errs = errs + 1;  // start or stop inside a byte
            active   = (sda === 1'b0);
            pull_r   = 1'b0;
            slave_tx = 1'b0;
            go_tx    = 1'b0;
            bitn     = 0;
            byte_idx = 0;
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

`default_nettype wire

/* src/eeprom_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module eeprom_ctrl
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_cmd_pkg::ee_addr_t addr,
    input  eeprom_cmd_pkg::ee_byte_t wr_data,
    input  logic                     sda_in,
    output logic                     busy,
    output logic                     ack,
    output logic                     nack,
    output eeprom_cmd_pkg::ee_byte_t rd_data,
    output logic                     scl,
    output logic                     sda_oe
);

    eeprom_cmd_pkg::ee_cmd_t  cmd;
    logic                     cmd_go;
    logic                     cmd_done;
    logic                     done_nack;
    eeprom_cmd_pkg::ee_byte_t done_data;
    eeprom_bus_pkg::ee_sym_t  sym;
    logic                     sym_go;
    logic                     sym_done;
    logic                     sym_ack;
    eeprom_cmd_pkg::ee_byte_t sym_rx;

    eeprom_req_stage u_req (.CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr),
        .wr_data(wr_data), .cmd_done(cmd_done), .done_nack(done_nack),
        .done_data(done_data), .busy(busy), .ack(ack), .nack(nack), .rd_data(rd_data),
        .cmd_go(cmd_go), .cmd(cmd));

    eeprom_frame_seq u_seq (.CLK(CLK), .RESET(RESET), .cmd_go(cmd_go), .cmd(cmd),
        .sym_done(sym_done), .sym_ack(sym_ack), .sym_rx(sym_rx), .sym_go(sym_go),
        .sym(sym), .cmd_done(cmd_done), .done_nack(done_nack), .done_data(done_data));

    eeprom_bit_engine u_bit (.CLK(CLK), .RESET(RESET), .sym_go(sym_go), .sym(sym),
        .sda_in(sda_in), .scl(scl), .sda_oe(sda_oe), .sym_done(sym_done),
        .sym_ack(sym_ack), .sym_rx(sym_rx));

endmodule

`default_nettype wire

/* src/eeprom_bit_engine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eeprom_defs.svh"

module eeprom_bit_engine
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     sym_go,
    input  eeprom_bus_pkg::ee_sym_t  sym,
    input  logic                     sda_in,
    output logic                     scl,
    output logic                     sda_oe,
    output logic                     sym_done,
    output logic                     sym_ack,
    output eeprom_cmd_pkg::ee_byte_t sym_rx
);

    localparam int              CW        = $clog2(`EE_SCL_HALF + 1);
    localparam logic [CW-1:0]   HALF_LAST = CW'(`EE_SCL_HALF - 1);
    localparam logic [3:0]      ACK_BIT   = 4'd8;  // ninth slot of a byte

    eeprom_bus_pkg::ee_bit_phase_t phase;
    eeprom_bus_pkg::ee_sym_kind_t  kind;
    eeprom_cmd_pkg::ee_byte_t      shreg;
    logic [CW-1:0]                 half_cnt;
    logic [3:0]                    bit_cnt;
    logic                          cond_sym;
    logic                          half_end;
    logic                          sym_end;
    logic                          drive_bit;

    // start and stop are a single low/high pair
    assign cond_sym = (kind == eeprom_bus_pkg::SYM_START) ||
                      (kind == eeprom_bus_pkg::SYM_STOP);
    assign half_end = (half_cnt == HALF_LAST);
    assign sym_end  = half_end && (cond_sym || bit_cnt == ACK_BIT);

    // pull-down wanted during the low half of the current slot
    always_comb
    begin
        case (kind)
            eeprom_bus_pkg::SYM_START: drive_bit = 1'b0;  // sda up before it falls
            eeprom_bus_pkg::SYM_STOP:  drive_bit = 1'b1;
            eeprom_bus_pkg::SYM_TX:    drive_bit = (bit_cnt != ACK_BIT) && !shreg[7];
            default:                   drive_bit = 1'b0;  // rx bits and master nack
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase    <= eeprom_bus_pkg::PH_IDLE;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
            sym_done <= 1'b0;
            sym_ack  <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
        end
        else
        begin
            sym_done <= 1'b0;
            case (phase)
                eeprom_bus_pkg::PH_IDLE:
                    if (sym_go)
                    begin
                        kind     <= sym.kind;
                        shreg    <= sym.tx;
                        bit_cnt  <= '0;
                        half_cnt <= '0;
                        scl      <= 1'b0;
                        phase    <= eeprom_bus_pkg::PH_LOW;
                    end
                eeprom_bus_pkg::PH_LOW:
                begin
                    if (half_cnt == '0)
                        sda_oe <= drive_bit;  // one clk after scl fell
                    if (half_end)
                    begin
                        half_cnt <= '0;
                        scl      <= 1'b1;
                        phase    <= eeprom_bus_pkg::PH_HIGH;
                    end
                    else
                        half_cnt <= half_cnt + 1'b1;
                end
                eeprom_bus_pkg::PH_HIGH:
                    if (!half_end)
                        half_cnt <= half_cnt + 1'b1;
                    else if (sym_end)
                    begin
                        // start pulls sda low, stop lets it rise, scl stays high
                        sda_oe   <= (kind == eeprom_bus_pkg::SYM_START);
                        sym_done <= 1'b1;
                        sym_rx   <= shreg;
                        phase    <= eeprom_bus_pkg::PH_IDLE;
                        if (!cond_sym)
                            sym_ack <= !sda_in;  // slave low means ack
                    end
                    else
                    begin
                        shreg    <= {shreg[6:0], sda_in};  // tx out msb, rx in lsb
                        bit_cnt  <= bit_cnt + 1'b1;
                        half_cnt <= '0;
                        scl      <= 1'b0;
                        phase    <= eeprom_bus_pkg::PH_LOW;
                    end
                default:
                    phase <= eeprom_bus_pkg::PH_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/eeprom_frame_seq.sv */
`timescale 1ns/1ns
`default_nettype none

module eeprom_frame_seq
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     cmd_go,
    input  eeprom_cmd_pkg::ee_cmd_t  cmd,
    input  logic                     sym_done,
    input  logic                     sym_ack,
    input  eeprom_cmd_pkg::ee_byte_t sym_rx,
    output logic                     sym_go,
    output eeprom_bus_pkg::ee_sym_t  sym,
    output logic                     cmd_done,
    output logic                     done_nack,
    output eeprom_cmd_pkg::ee_byte_t done_data
);

    typedef enum logic [3:0]
    {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_CTRL_R,
        S_READ,
        S_STOP
    } state_t;

    state_t                  state;
    eeprom_cmd_pkg::ee_cmd_t cmd_r;
    logic                    tx_state;

    function automatic eeprom_bus_pkg::ee_sym_t mk_sym(
        input eeprom_bus_pkg::ee_sym_kind_t kind,
        input eeprom_cmd_pkg::ee_byte_t     tx
    );
        eeprom_bus_pkg::ee_sym_t s;
        s.kind = kind;
        s.tx   = tx;
        return s;
    endfunction

    // states whose symbol ends in a slave acknowledge slot
    assign tx_state = (state == S_CTRL_W) || (state == S_ADDR) ||
                      (state == S_DATA) || (state == S_CTRL_R);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            sym_go    <= 1'b0;
            cmd_done  <= 1'b0;
            done_nack <= 1'b0;
        end
        else
        begin
            sym_go   <= 1'b0;
            cmd_done <= 1'b0;
            if (state == S_IDLE)
            begin
                if (cmd_go)
                begin
                    cmd_r     <= cmd;
                    done_nack <= 1'b0;
                    sym_go    <= 1'b1;
                    sym       <= mk_sym(eeprom_bus_pkg::SYM_START, 8'h00);
                    state     <= S_START;
                end
            end
            else if (sym_done)
            begin
                sym_go <= (state != S_STOP);
                if (tx_state && !sym_ack)
                begin
                    done_nack <= 1'b1;  // no ack, close the frame
                    sym       <= mk_sym(eeprom_bus_pkg::SYM_STOP, 8'h00);
                    state     <= S_STOP;
                end
                else
                begin
                    case (state)
                        S_START:
                        begin
                            sym   <= mk_sym(eeprom_bus_pkg::SYM_TX, cmd_r.ctrl_wr);
                            state <= S_CTRL_W;
                        end
                        S_CTRL_W:
                        begin
                            sym   <= mk_sym(eeprom_bus_pkg::SYM_TX, cmd_r.word_addr);
                            state <= S_ADDR;
                        end
                        S_ADDR:
                            if (cmd_r.op == eeprom_cmd_pkg::OP_WRITE)
                            begin
                                sym   <= mk_sym(eeprom_bus_pkg::SYM_TX, cmd_r.data);
                                state <= S_DATA;
                            end
                            else
                            begin
                                sym   <= mk_sym(eeprom_bus_pkg::SYM_START, 8'h00); // repeated
                                state <= S_RSTART;
                            end
                        S_RSTART:
                        begin
                            sym   <= mk_sym(eeprom_bus_pkg::SYM_TX, cmd_r.ctrl_rd);
                            state <= S_CTRL_R;
                        end
                        S_CTRL_R:
                        begin
                            sym   <= mk_sym(eeprom_bus_pkg::SYM_RX, 8'h00);
                            state <= S_READ;
                        end
                        S_DATA, S_READ:
                        begin
                            if (state == S_READ)
                                done_data <= sym_rx;
                            sym   <= mk_sym(eeprom_bus_pkg::SYM_STOP, 8'h00);
                            state <= S_STOP;
                        end
                        default:
                        begin
                            cmd_done <= 1'b1;  // stop is out, frame over
                            state    <= S_IDLE;
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/eeprom_req_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eeprom_defs.svh"

module eeprom_req_stage
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_cmd_pkg::ee_addr_t addr,
    input  eeprom_cmd_pkg::ee_byte_t wr_data,
    input  logic                     cmd_done,
    input  logic                     done_nack,
    input  eeprom_cmd_pkg::ee_byte_t done_data,
    output logic                     busy,
    output logic                     ack,
    output logic                     nack,
    output eeprom_cmd_pkg::ee_byte_t rd_data,
    output logic                     cmd_go,
    output eeprom_cmd_pkg::ee_cmd_t  cmd
);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            ack     <= 1'b0;
            nack    <= 1'b0;
            rd_data <= '0;
            cmd_go  <= 1'b0;
        end
        else
        begin
            ack    <= 1'b0;
            cmd_go <= 1'b0;
            if (!busy && (wr || rd))
            begin
                busy          <= 1'b1;
                cmd_go        <= 1'b1;
                cmd.op        <= wr ? eeprom_cmd_pkg::OP_WRITE : eeprom_cmd_pkg::OP_READ;
                cmd.ctrl_wr   <= {`EE_DEV_CODE, addr[10:8], 1'b0};
                cmd.ctrl_rd   <= {`EE_DEV_CODE, addr[10:8], 1'b1};
                cmd.word_addr <= addr[7:0];
                cmd.data      <= wr_data;
            end
            else if (busy && cmd_done)
            begin
                busy <= 1'b0;
                ack  <= 1'b1;
                nack <= done_nack;
                if (cmd.op == eeprom_cmd_pkg::OP_READ && !done_nack)
                    rd_data <= done_data;  // last good read is kept
            end
        end
    end

endmodule

`default_nettype wire

/* src/eeprom_bus_pkg.sv */
`default_nettype none

package eeprom_bus_pkg;

    typedef enum logic [1:0]
    {
        SYM_START,
        SYM_TX,
        SYM_RX,
        SYM_STOP
    } ee_sym_kind_t;

    // one bus symbol, tx unused for start, stop and rx
    typedef struct packed
    {
        ee_sym_kind_t             kind;
        eeprom_cmd_pkg::ee_byte_t tx;
    } ee_sym_t;

    // bit engine phases
    typedef enum logic [1:0]
    {
        PH_IDLE,
        PH_LOW,   // scl low, sda may change
        PH_HIGH
    } ee_bit_phase_t;

endpackage

`default_nettype wire

/* src/eeprom_cmd_pkg.sv */
`default_nettype none

package eeprom_cmd_pkg;

    // memory address, bits 10:8 pick the block
    typedef logic [10:0] ee_addr_t;

    typedef logic [7:0] ee_byte_t;

    typedef enum logic
    {
        OP_WRITE,
        OP_READ
    } ee_op_t;

    // command ready for framing
    typedef struct packed
    {
        ee_op_t   op;
        ee_byte_t ctrl_wr;   // control byte, write form
        ee_byte_t ctrl_rd;   // control byte, read form
        ee_byte_t word_addr; // low address byte
        ee_byte_t data;
    } ee_cmd_t;

endpackage

`default_nettype wire

/* src/eeprom_defs.svh */
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// CLK cycles per SCL half period, 1 or more
`define EE_SCL_HALF 2

// device type code, upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// 2 Kbyte part, 11-bit address
`define EE_MEM_BYTES 2048

`endif
